// ==== include/id_defines.svh ====
////////////////////////////////////////////////////////////
// Decode stage widths and constants
////////////////////////////////////////////////////////////

`ifndef ID_DEFINES_SVH
`define ID_DEFINES_SVH

// Data path and operand width
`define ID_XLEN 32

// Instruction word width
`define ID_INSTR_W 32

// Register file address width
`define ID_REG_AW 5

// Sequential PC step, used for the link address
`define ID_PC_INCR 4

`endif

// ==== verilog/id_pkg.sv ====
////////////////////////////////////////////////////////////
// Decode stage types
// Opcodes, ALU operations, mux selects and the instruction
// word with its R, I and S views
////////////////////////////////////////////////////////////

`default_nettype none

package id_pkg;

  // Major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    OPCODE_LOAD   = 7'h03,
    OPCODE_OP_IMM = 7'h13,
    OPCODE_AUIPC  = 7'h17,
    OPCODE_STORE  = 7'h23,
    OPCODE_OP     = 7'h33,
    OPCODE_LUI    = 7'h37,
    OPCODE_BRANCH = 7'h63,
    OPCODE_JALR   = 7'h67,
    OPCODE_JAL    = 7'h6f
  } opcode_e;

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
    // Comparisons for branches
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REG_A, OP_A_CURRPC, OP_A_ZERO} op_a_sel_e;

  typedef enum logic {OP_B_REG_B, OP_B_IMM} op_b_sel_e;

  typedef enum logic [2:0] {
    IMM_B_I, IMM_B_S, IMM_B_B, IMM_B_U, IMM_B_J, IMM_B_INCR_PC
  } imm_b_sel_e;

  typedef enum logic [1:0] {LSU_WORD = 2'b00, LSU_HALF = 2'b01, LSU_BYTE = 2'b10} lsu_type_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } instr_r_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } instr_i_t;

  // Also carries the B-type immediate bits
  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    opcode_e    opcode;
  } instr_s_t;

  typedef union packed {
    instr_r_t r;
    instr_i_t i;
    instr_s_t s;
  } instr_u;

endpackage

`default_nettype wire

// ==== verilog/id_ctrl_if.sv ====
////////////////////////////////////////////////////////////
// Decoded control from the decoder to the operand muxes
// and the issue FSM
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface id_ctrl_if;
  import id_pkg::*;

  // Operand selection
  op_a_sel_e  op_a_sel;
  op_b_sel_e  op_b_sel;
  imm_b_sel_e imm_b_sel;

  // Instruction class, cleared for illegal encodings
  logic       lsu_req;
  logic       branch;
  logic       jump;
  logic       rf_we;
  logic       illegal;

  modport dec (output op_a_sel, op_b_sel, imm_b_sel,
               output lsu_req, branch, jump, rf_we, illegal);

  modport mux (input op_a_sel, op_b_sel, imm_b_sel);

  modport fsm (input lsu_req, branch, jump, rf_we, illegal);

endinterface

`default_nettype wire

// ==== verilog/id_decoder.sv ====
////////////////////////////////////////////////////////////
// Instruction decoder
// ALU operation, operand selects, LSU attributes, register
// addresses and illegal instruction detection
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "id_defines.svh"

module id_decoder (
  input  id_pkg::instr_u         instr_rdata_i,
  input  logic                   instr_first_cycle_i,
  output logic [`ID_REG_AW-1:0]  rf_raddr_a_o,
  output logic [`ID_REG_AW-1:0]  rf_raddr_b_o,
  output logic [`ID_REG_AW-1:0]  rf_waddr_o,
  output id_pkg::alu_op_e        alu_operator_o,
  output logic                   lsu_we_o,
  output id_pkg::lsu_type_e      lsu_type_o,
  output logic                   lsu_sign_ext_o,
  id_ctrl_if.dec                 ctrl
);
  import id_pkg::*;

  logic lsu_req_dec;
  logic branch_dec;
  logic jump_dec;
  logic rf_we_dec;
  logic illegal_dec;

  assign rf_raddr_a_o = instr_rdata_i.r.rs1;
  assign rf_raddr_b_o = instr_rdata_i.r.rs2;
  assign rf_waddr_o   = instr_rdata_i.r.rd;

  always_comb begin
    alu_operator_o = ALU_ADD;
    ctrl.op_a_sel  = OP_A_REG_A;
    ctrl.op_b_sel  = OP_B_IMM;
    ctrl.imm_b_sel = IMM_B_I;
    lsu_req_dec    = 1'b0;
    lsu_we_o       = 1'b0;
    lsu_type_o     = LSU_WORD;
    lsu_sign_ext_o = 1'b0;
    branch_dec     = 1'b0;
    jump_dec       = 1'b0;
    rf_we_dec      = 1'b0;
    illegal_dec    = 1'b0;

    unique case (instr_rdata_i.r.opcode)
      OPCODE_LUI: begin
        ctrl.op_a_sel  = OP_A_ZERO;
        ctrl.imm_b_sel = IMM_B_U;
        rf_we_dec      = 1'b1;
      end
      OPCODE_AUIPC: begin
        ctrl.op_a_sel  = OP_A_CURRPC;
        ctrl.imm_b_sel = IMM_B_U;
        rf_we_dec      = 1'b1;
      end
      OPCODE_OP_IMM: begin
        rf_we_dec = 1'b1;
        unique case (instr_rdata_i.r.funct3)
          3'b000: alu_operator_o = ALU_ADD;
          3'b010: alu_operator_o = ALU_SLT;
          3'b011: alu_operator_o = ALU_SLTU;
          3'b100: alu_operator_o = ALU_XOR;
          3'b110: alu_operator_o = ALU_OR;
          3'b111: alu_operator_o = ALU_AND;
          3'b001: begin
            alu_operator_o = ALU_SLL;
            illegal_dec    = (instr_rdata_i.r.funct7 != 7'b000_0000);
          end
          default: begin
            // Shift right, funct7 picks logical or arithmetic
            if (instr_rdata_i.r.funct7 == 7'b000_0000) begin
              alu_operator_o = ALU_SRL;
            end else if (instr_rdata_i.r.funct7 == 7'b010_0000) begin
              alu_operator_o = ALU_SRA;
            end else begin
              illegal_dec = 1'b1;
            end
          end
        endcase
      end
      OPCODE_OP: begin
        ctrl.op_b_sel = OP_B_REG_B;
        rf_we_dec     = 1'b1;
        unique case ({instr_rdata_i.r.funct7, instr_rdata_i.r.funct3})
          {7'b000_0000, 3'b000}: alu_operator_o = ALU_ADD;
          {7'b010_0000, 3'b000}: alu_operator_o = ALU_SUB;
          {7'b000_0000, 3'b001}: alu_operator_o = ALU_SLL;
          {7'b000_0000, 3'b010}: alu_operator_o = ALU_SLT;
          {7'b000_0000, 3'b011}: alu_operator_o = ALU_SLTU;
          {7'b000_0000, 3'b100}: alu_operator_o = ALU_XOR;
          {7'b000_0000, 3'b101}: alu_operator_o = ALU_SRL;
          {7'b010_0000, 3'b101}: alu_operator_o = ALU_SRA;
          {7'b000_0000, 3'b110}: alu_operator_o = ALU_OR;
          {7'b000_0000, 3'b111}: alu_operator_o = ALU_AND;
          default:               illegal_dec    = 1'b1;
        endcase
      end
      OPCODE_LOAD: begin
        lsu_req_dec    = 1'b1;
        rf_we_dec      = 1'b1;
        // funct3[2] marks the unsigned variants
        lsu_sign_ext_o = ~instr_rdata_i.i.funct3[2];
        unique case (instr_rdata_i.i.funct3)
          3'b000, 3'b100: lsu_type_o  = LSU_BYTE;
          3'b001, 3'b101: lsu_type_o  = LSU_HALF;
          3'b010:         lsu_type_o  = LSU_WORD;
          default:        illegal_dec = 1'b1;
        endcase
      end
      OPCODE_STORE: begin
        lsu_req_dec    = 1'b1;
        lsu_we_o       = 1'b1;
        ctrl.imm_b_sel = IMM_B_S;
        unique case (instr_rdata_i.s.funct3)
          3'b000:  lsu_type_o  = LSU_BYTE;
          3'b001:  lsu_type_o  = LSU_HALF;
          3'b010:  lsu_type_o  = LSU_WORD;
          default: illegal_dec = 1'b1;
        endcase
      end
      OPCODE_BRANCH: begin
        branch_dec = 1'b1;
        unique case (instr_rdata_i.s.funct3)
          3'b000:  alu_operator_o = ALU_EQ;
          3'b001:  alu_operator_o = ALU_NE;
          3'b100:  alu_operator_o = ALU_LT;
          3'b101:  alu_operator_o = ALU_GE;
          3'b110:  alu_operator_o = ALU_LTU;
          3'b111:  alu_operator_o = ALU_GEU;
          default: illegal_dec    = 1'b1;
        endcase
        if (instr_first_cycle_i) begin
          // Compare rs1 with rs2
          ctrl.op_b_sel = OP_B_REG_B;
        end else begin
          // Taken, compute the target
          alu_operator_o = ALU_ADD;
          ctrl.op_a_sel  = OP_A_CURRPC;
          ctrl.imm_b_sel = IMM_B_B;
        end
      end
      OPCODE_JAL, OPCODE_JALR: begin
        jump_dec    = 1'b1;
        rf_we_dec   = 1'b1;
        illegal_dec = (instr_rdata_i.i.opcode == OPCODE_JALR) &&
                      (instr_rdata_i.i.funct3 != 3'b000);
        if (!instr_first_cycle_i) begin
          // Link address
          ctrl.op_a_sel  = OP_A_CURRPC;
          ctrl.imm_b_sel = IMM_B_INCR_PC;
        end else if (instr_rdata_i.i.opcode == OPCODE_JAL) begin
          ctrl.op_a_sel  = OP_A_CURRPC;
          ctrl.imm_b_sel = IMM_B_J;
        end
      end
      default: begin
        illegal_dec = 1'b1;
      end
    endcase
  end

  // An illegal encoding must not request, write or redirect
  assign ctrl.lsu_req = lsu_req_dec & ~illegal_dec;
  assign ctrl.branch  = branch_dec  & ~illegal_dec;
  assign ctrl.jump    = jump_dec    & ~illegal_dec;
  assign ctrl.rf_we   = rf_we_dec   & ~illegal_dec;
  assign ctrl.illegal = illegal_dec;

endmodule

`default_nettype wire

// ==== verilog/id_operand_mux.sv ====
////////////////////////////////////////////////////////////
// Immediate generation and main ALU operand selection
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "id_defines.svh"

module id_operand_mux (
  input  id_pkg::instr_u        instr_rdata_i,
  input  logic [`ID_XLEN-1:0]   pc_id_i,
  input  logic [`ID_XLEN-1:0]   rf_rdata_a_i,
  input  logic [`ID_XLEN-1:0]   rf_rdata_b_i,
  output logic [`ID_XLEN-1:0]   alu_operand_a_o,
  output logic [`ID_XLEN-1:0]   alu_operand_b_o,
  id_ctrl_if.mux                ctrl
);
  import id_pkg::*;

  logic [`ID_XLEN-1:0] imm_i_type;
  logic [`ID_XLEN-1:0] imm_s_type;
  logic [`ID_XLEN-1:0] imm_b_type;
  logic [`ID_XLEN-1:0] imm_u_type;
  logic [`ID_XLEN-1:0] imm_j_type;
  logic [`ID_XLEN-1:0] imm_b;

  ////////////////////////////////////////////////////////////
  // Immediates
  ////////////////////////////////////////////////////////////

  assign imm_i_type = {{20{instr_rdata_i.i.imm12[11]}}, instr_rdata_i.i.imm12};
  assign imm_s_type = {{20{instr_rdata_i.s.imm_hi[6]}}, instr_rdata_i.s.imm_hi,
                       instr_rdata_i.s.imm_lo};
  // B type reuses the S fields with bits 11 and 12 swapped in
  assign imm_b_type = {{19{instr_rdata_i.s.imm_hi[6]}}, instr_rdata_i.s.imm_hi[6],
                       instr_rdata_i.s.imm_lo[0], instr_rdata_i.s.imm_hi[5:0],
                       instr_rdata_i.s.imm_lo[4:1], 1'b0};
  assign imm_u_type = {instr_rdata_i.i.imm12, instr_rdata_i.i.rs1,
                       instr_rdata_i.i.funct3, 12'h000};
  assign imm_j_type = {{12{instr_rdata_i.i.imm12[11]}}, instr_rdata_i.i.rs1,
                       instr_rdata_i.i.funct3, instr_rdata_i.i.imm12[0],
                       instr_rdata_i.i.imm12[10:1], 1'b0};

  ////////////////////////////////////////////////////////////
  // Operand muxes
  ////////////////////////////////////////////////////////////

  always_comb begin
    unique case (ctrl.imm_b_sel)
      IMM_B_I:       imm_b = imm_i_type;
      IMM_B_S:       imm_b = imm_s_type;
      IMM_B_B:       imm_b = imm_b_type;
      IMM_B_U:       imm_b = imm_u_type;
      IMM_B_J:       imm_b = imm_j_type;
      default:       imm_b = `ID_XLEN'(`ID_PC_INCR);
    endcase
  end

  always_comb begin
    unique case (ctrl.op_a_sel)
      OP_A_REG_A:  alu_operand_a_o = rf_rdata_a_i;
      OP_A_CURRPC: alu_operand_a_o = pc_id_i;
      default:     alu_operand_a_o = '0;
    endcase
  end

  assign alu_operand_b_o = (ctrl.op_b_sel == OP_B_IMM) ? imm_b : rf_rdata_b_i;

endmodule

`default_nettype wire

// ==== verilog/id_issue_fsm.sv ====
////////////////////////////////////////////////////////////
// Issue FSM
// First-cycle/multi-cycle sequencing, stalls, completion
// and the registered branch set
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module id_issue_fsm (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   instr_valid_i,
  input  logic   branch_decision_i,
  input  logic   lsu_valid_i,
  input  logic   lsu_we_i,
  id_ctrl_if.fsm ctrl,
  output logic   instr_first_cycle_o,
  output logic   instr_id_done_o,
  output logic   illegal_insn_o,
  output logic   lsu_req_o,
  output logic   branch_set_o,
  output logic   jump_set_o,
  output logic   rf_we_o
);

  typedef enum logic {FIRST_CYCLE, MULTI_CYCLE} id_fsm_e;

  id_fsm_e fsm_q;
  id_fsm_e fsm_d;
  logic    branch_set_d;
  logic    branch_set_q;
  logic    stall_mem;
  logic    stall_branch;
  logic    stall_jump;
  logic    multicycle_done;

  assign instr_first_cycle_o = instr_valid_i & (fsm_q == FIRST_CYCLE);

  // Branches and jumps finish in their second cycle, memory ops wait for the LSU
  assign multicycle_done = ~ctrl.lsu_req | lsu_valid_i;

  always_comb begin
    fsm_d        = fsm_q;
    stall_branch = 1'b0;
    stall_jump   = 1'b0;
    branch_set_d = 1'b0;

    if (instr_valid_i) begin
      unique case (fsm_q)
        FIRST_CYCLE: begin
          if (ctrl.lsu_req) begin
            fsm_d = MULTI_CYCLE;
          end else if (ctrl.branch) begin
            // Only a taken branch needs the target cycle
            fsm_d        = branch_decision_i ? MULTI_CYCLE : FIRST_CYCLE;
            stall_branch = branch_decision_i;
            branch_set_d = branch_decision_i;
          end else if (ctrl.jump) begin
            fsm_d      = MULTI_CYCLE;
            stall_jump = 1'b1;
          end
        end
        default: begin
          if (multicycle_done) begin
            fsm_d = FIRST_CYCLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fsm_q        <= FIRST_CYCLE;
      branch_set_q <= 1'b0;
    end else begin
      fsm_q        <= fsm_d;
      branch_set_q <= branch_set_d;
    end
  end

  // Load/store always holds its first cycle, then waits for the LSU
  assign stall_mem = instr_valid_i & ctrl.lsu_req & (~lsu_valid_i | instr_first_cycle_o);

  assign instr_id_done_o = instr_valid_i & ~stall_mem & ~stall_branch & ~stall_jump;

  assign illegal_insn_o = instr_valid_i & ctrl.illegal;
  assign lsu_req_o      = instr_first_cycle_o & ctrl.lsu_req;
  assign jump_set_o     = instr_first_cycle_o & ctrl.jump;
  assign branch_set_o   = branch_set_q;

  // Stores never write, everything else writes on completion
  assign rf_we_o = ctrl.rf_we & ~lsu_we_i & instr_id_done_o;

endmodule

`default_nettype wire

// ==== verilog/id_stage.sv ====
////////////////////////////////////////////////////////////
// RV32I decode and issue stage
// Decoder, operand muxes and issue FSM
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "id_defines.svh"

module id_stage (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Fetch handshake
  input  logic                   instr_valid_i,
  input  logic [`ID_INSTR_W-1:0] instr_rdata_i,
  input  logic [`ID_XLEN-1:0]    pc_id_i,
  input  logic                   branch_decision_i,
  input  logic                   lsu_valid_i,
  input  logic [`ID_XLEN-1:0]    rf_rdata_a_i,
  input  logic [`ID_XLEN-1:0]    rf_rdata_b_i,
  output logic                   instr_id_done_o,
  output logic                   illegal_insn_o,
  // Register file
  output logic [`ID_REG_AW-1:0]  rf_raddr_a_o,
  output logic [`ID_REG_AW-1:0]  rf_raddr_b_o,
  output logic [`ID_REG_AW-1:0]  rf_waddr_o,
  output logic                   rf_we_o,
  // Main ALU
  output id_pkg::alu_op_e        alu_operator_o,
  output logic [`ID_XLEN-1:0]    alu_operand_a_o,
  output logic [`ID_XLEN-1:0]    alu_operand_b_o,
  // LSU
  output logic                   lsu_req_o,
  output logic                   lsu_we_o,
  output id_pkg::lsu_type_e      lsu_type_o,
  output logic                   lsu_sign_ext_o,
  output logic [`ID_XLEN-1:0]    lsu_wdata_o,
  // PC redirect
  output logic                   branch_set_o,
  output logic                   jump_set_o
);
  import id_pkg::*;

  instr_u instr_word;
  logic   instr_first_cycle;

  id_ctrl_if ctrl_if ();

  assign instr_word  = instr_rdata_i;
  assign lsu_wdata_o = rf_rdata_b_i;

  id_decoder u_decoder (
    .instr_rdata_i       (instr_word),
    .instr_first_cycle_i (instr_first_cycle),
    .rf_raddr_a_o        (rf_raddr_a_o),
    .rf_raddr_b_o        (rf_raddr_b_o),
    .rf_waddr_o          (rf_waddr_o),
    .alu_operator_o      (alu_operator_o),
    .lsu_we_o            (lsu_we_o),
    .lsu_type_o          (lsu_type_o),
    .lsu_sign_ext_o      (lsu_sign_ext_o),
    .ctrl                (ctrl_if.dec)
  );

  id_operand_mux u_operand_mux (
    .instr_rdata_i   (instr_word),
    .pc_id_i         (pc_id_i),
    .rf_rdata_a_i    (rf_rdata_a_i),
    .rf_rdata_b_i    (rf_rdata_b_i),
    .alu_operand_a_o (alu_operand_a_o),
    .alu_operand_b_o (alu_operand_b_o),
    .ctrl            (ctrl_if.mux)
  );

  id_issue_fsm u_issue_fsm (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .instr_valid_i       (instr_valid_i),
    .branch_decision_i   (branch_decision_i),
    .lsu_valid_i         (lsu_valid_i),
    .lsu_we_i            (lsu_we_o),
    .ctrl                (ctrl_if.fsm),
    .instr_first_cycle_o (instr_first_cycle),
    .instr_id_done_o     (instr_id_done_o),
    .illegal_insn_o      (illegal_insn_o),
    .lsu_req_o           (lsu_req_o),
    .branch_set_o        (branch_set_o),
    .jump_set_o          (jump_set_o),
    .rf_we_o             (rf_we_o)
  );

endmodule

`default_nettype wire

// ==== verification/tb_id_stage.sv ====
////////////////////////////////////////////////////////////
// Testbench for the decode and issue stage
// Builds RV32I words, models the expected outputs and
// checks them with assertions
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "id_defines.svh"

module tb_id_stage;
  import id_pkg::*;

  localparam int TIMEOUT = 20;

  logic                   clk_i = 1'b0;
  logic                   rst_ni;
  logic                   instr_valid_i;
  logic [`ID_INSTR_W-1:0] instr_rdata_i;
  logic [`ID_XLEN-1:0]    pc_id_i;
  logic                   branch_decision_i;
  logic                   lsu_valid_i;
  logic [`ID_XLEN-1:0]    rf_rdata_a_i;
  logic [`ID_XLEN-1:0]    rf_rdata_b_i;
  logic                   instr_id_done_o;
  logic                   illegal_insn_o;
  logic [`ID_REG_AW-1:0]  rf_raddr_a_o;
  logic [`ID_REG_AW-1:0]  rf_raddr_b_o;
  logic [`ID_REG_AW-1:0]  rf_waddr_o;
  logic                   rf_we_o;
  alu_op_e                alu_operator_o;
  logic [`ID_XLEN-1:0]    alu_operand_a_o;
  logic [`ID_XLEN-1:0]    alu_operand_b_o;
  logic                   lsu_req_o;
  logic                   lsu_we_o;
  lsu_type_e              lsu_type_o;
  logic                   lsu_sign_ext_o;
  logic [`ID_XLEN-1:0]    lsu_wdata_o;
  logic                   branch_set_o;
  logic                   jump_set_o;

  integer      seed = 32'hb257_2a11;
  int          n_checks = 0;
  int          n_errors = 0;
  int          n_tests = 0;
  int          err_base = 0;
  logic [31:0] r;

  always #2 clk_i = ~clk_i;

  id_stage UUT (.*);

  ////////////////////////////////////////////////////////////
  // Protocol properties
  ////////////////////////////////////////////////////////////

  a_lsu_req_once: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lsu_req_o |=> !lsu_req_o)
    else begin
      $display("LSU request stayed high for more than one cycle at %0t", $time);
      n_errors++;
    end

  a_branch_set_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    branch_set_o |-> instr_id_done_o)
    else begin
      $display("Branch set without completion at %0t", $time);
      n_errors++;
    end

  a_illegal_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
    illegal_insn_o |-> !lsu_req_o && !rf_we_o && !jump_set_o && !branch_set_o)
    else begin
      $display("Illegal instruction caused a side effect at %0t", $time);
      n_errors++;
    end

  // Immediates as the RV32I encoding defines them
  function automatic logic [31:0] imm_i(input logic [31:0] iw);
    return {{20{iw[31]}}, iw[31:20]};
  endfunction

  function automatic logic [31:0] imm_s(input logic [31:0] iw);
    return {{20{iw[31]}}, iw[31:25], iw[11:7]};
  endfunction

  function automatic logic [31:0] imm_b(input logic [31:0] iw);
    return {{20{iw[31]}}, iw[7], iw[30:25], iw[11:8], 1'b0};
  endfunction

  function automatic logic [31:0] imm_j(input logic [31:0] iw);
    return {{12{iw[31]}}, iw[19:12], iw[20], iw[30:21], 1'b0};
  endfunction

  task automatic check(input string sig, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    assert (exp === act)
      else begin
        $display("Fail at %0t: %s expected %h actual %h", $time, sig, exp, act);
        n_errors++;
      end
  endtask

  task automatic idle_check();
    check("instr_id_done_o", 0, 32'(instr_id_done_o));
    check("illegal_insn_o", 0, 32'(illegal_insn_o));
    check("rf_we_o", 0, 32'(rf_we_o));
    check("lsu_req_o", 0, 32'(lsu_req_o));
    check("branch_set_o", 0, 32'(branch_set_o));
    check("jump_set_o", 0, 32'(jump_set_o));
  endtask

  task automatic end_test(input string name);
    n_tests++;
    $display("Test %-12s %s (%0d errors)", name,
             (n_errors == err_base) ? "ok" : "failed", n_errors - err_base);
    err_base = n_errors;
  endtask

  // Presents one instruction and follows it until done
  task automatic issue(input logic [31:0] iw, input alu_op_e exp_op, input logic bad,
                       input logic taken, input int lsu_delay);
    logic [6:0]  opc;
    logic        is_mem;
    logic        is_st;
    logic        is_br;
    logic        is_jmp;
    logic        wr;
    logic        done_exp;
    logic        fin;
    logic        exp_sext;
    logic [31:0] ra;
    logic [31:0] rb;
    logic [31:0] pc;
    logic [31:0] exp_a;
    logic [31:0] exp_b;
    logic [1:0]  exp_type;
    int          cyc;
    opc    = iw[6:0];
    is_mem = !bad && (opc == 7'h03 || opc == 7'h23);
    is_st  = !bad && (opc == 7'h23);
    is_br  = !bad && (opc == 7'h63);
    is_jmp = !bad && (opc == 7'h6f || opc == 7'h67);
    wr     = !bad && !is_st && !is_br;
    ra     = $random(seed);
    rb     = $random(seed);
    pc     = $random(seed);
    pc[1:0] = 2'b00;
    exp_type = (iw[13:12] == 2'd0) ? 2'b10 : (iw[13:12] == 2'd1) ? 2'b01 : 2'b00;
    // LBU and LHU zero extend
    exp_sext = !is_st && (iw[14:12] != 3'b100) && (iw[14:12] != 3'b101);
    case (opc)
      7'h33, 7'h63: begin
        exp_a = ra;
        exp_b = rb;
      end
      7'h13, 7'h03, 7'h67: begin
        exp_a = ra;
        exp_b = imm_i(iw);
      end
      7'h23: begin
        exp_a = ra;
        exp_b = imm_s(iw);
      end
      7'h37: begin
        exp_a = 0;
        exp_b = {iw[31:12], 12'h000};
      end
      7'h17: begin
        exp_a = pc;
        exp_b = {iw[31:12], 12'h000};
      end
      default: begin
        exp_a = pc;
        exp_b = imm_j(iw);
      end
    endcase
    instr_valid_i     = 1'b1;
    instr_rdata_i     = iw;
    pc_id_i           = pc;
    rf_rdata_a_i      = ra;
    rf_rdata_b_i      = rb;
    branch_decision_i = taken;
    lsu_valid_i       = 1'b0;
    cyc = 0;
    fin = 1'b0;
    while (!fin && cyc <= TIMEOUT) begin
      @(negedge clk_i);
      if (is_mem) done_exp = (cyc > 0) && (cyc == lsu_delay);
      else if (is_jmp || (is_br && taken)) done_exp = (cyc == 1);
      else done_exp = (cyc == 0);
      check("instr_id_done_o", 32'(done_exp), 32'(instr_id_done_o));
      check("illegal_insn_o", 32'(bad), 32'(illegal_insn_o));
      check("lsu_req_o", 32'(is_mem && cyc == 0), 32'(lsu_req_o));
      check("jump_set_o", 32'(is_jmp && cyc == 0), 32'(jump_set_o));
      check("branch_set_o", 32'(is_br && taken && cyc == 1), 32'(branch_set_o));
      check("rf_we_o", 32'(wr && done_exp), 32'(rf_we_o));
      if (cyc == 0) begin
        check("rf_raddr_a_o", 32'(iw[19:15]), 32'(rf_raddr_a_o));
        check("rf_raddr_b_o", 32'(iw[24:20]), 32'(rf_raddr_b_o));
        check("rf_waddr_o", 32'(iw[11:7]), 32'(rf_waddr_o));
      end
      if (cyc == 0 && !bad) begin
        check("alu_operator_o", 32'(exp_op), 32'(alu_operator_o));
        check("alu_operand_a_o", exp_a, alu_operand_a_o);
        check("alu_operand_b_o", exp_b, alu_operand_b_o);
      end
      // Target or link step
      if (cyc == 1 && (is_jmp || (is_br && taken))) begin
        check("alu_operator_o", 32'(ALU_ADD), 32'(alu_operator_o));
        check("alu_operand_a_o", pc, alu_operand_a_o);
        check("alu_operand_b_o", is_jmp ? 32'd4 : imm_b(iw), alu_operand_b_o);
      end
      if (is_mem && cyc == 0) begin
        check("lsu_we_o", 32'(is_st), 32'(lsu_we_o));
        check("lsu_type_o", 32'(exp_type), 32'(lsu_type_o));
        check("lsu_sign_ext_o", 32'(exp_sext), 32'(lsu_sign_ext_o));
        check("lsu_wdata_o", rb, lsu_wdata_o);
      end
      fin = instr_id_done_o;
      @(posedge clk_i);
      #1;
      cyc++;
      lsu_valid_i = is_mem && (cyc == lsu_delay);
    end
    if (!fin) begin
      $display("Timeout: instruction %h did not complete in %0d cycles", iw, TIMEOUT);
      n_errors++;
    end
    instr_valid_i     = 1'b0;
    lsu_valid_i       = 1'b0;
    branch_decision_i = 1'b0;
  endtask

  initial begin
    rst_ni            = 1'b0;
    instr_valid_i     = 1'b0;
    instr_rdata_i     = '0;
    pc_id_i           = '0;
    branch_decision_i = 1'b0;
    lsu_valid_i       = 1'b0;
    rf_rdata_a_i      = '0;
    rf_rdata_b_i      = '0;

    // Reset and then idle with junk on the instruction bus
    repeat (10) begin
      @(negedge clk_i);
      idle_check();
      @(posedge clk_i);
    end
    #1;
    rst_ni = 1'b1;
    repeat (5) begin
      instr_rdata_i = $random(seed);
      @(negedge clk_i);
      idle_check();
      @(posedge clk_i);
      #1;
    end
    end_test("reset_idle");

    repeat (2) begin
      r = $random(seed);
      issue({7'h00, r[24:20], r[19:15], 3'b000, r[11:7], 7'h33}, ALU_ADD, 0, 0, 0);
      issue({7'h20, r[24:20], r[19:15], 3'b000, r[11:7], 7'h33}, ALU_SUB, 0, 0, 0);
      issue({7'h00, r[24:20], r[19:15], 3'b001, r[11:7], 7'h33}, ALU_SLL, 0, 0, 0);
      issue({7'h20, r[24:20], r[19:15], 3'b101, r[11:7], 7'h33}, ALU_SRA, 0, 0, 0);
      issue({7'h00, r[24:20], r[19:15], 3'b010, r[11:7], 7'h33}, ALU_SLT, 0, 0, 0);
      issue({r[31:20], r[19:15], 3'b000, r[11:7], 7'h13}, ALU_ADD, 0, 0, 0);
      issue({r[31:20], r[19:15], 3'b100, r[11:7], 7'h13}, ALU_XOR, 0, 0, 0);
      issue({7'h00, r[24:20], r[19:15], 3'b101, r[11:7], 7'h13}, ALU_SRL, 0, 0, 0);
      issue({r[31:12], r[11:7], 7'h37}, ALU_ADD, 0, 0, 0);
      issue({r[31:12], r[11:7], 7'h17}, ALU_ADD, 0, 0, 0);
    end
    end_test("alu");

    repeat (3) begin
      r = $random(seed);
      issue({r[31:20], r[19:15], 3'b010, r[11:7], 7'h03}, ALU_ADD, 0, 0, 1 + int'(r[1:0]));
      issue({r[31:20], r[19:15], 3'b001, r[11:7], 7'h03}, ALU_ADD, 0, 0, 1 + int'(r[3:2]));
      issue({r[31:20], r[19:15], 3'b100, r[11:7], 7'h03}, ALU_ADD, 0, 0, 1 + int'(r[5:4]));
      issue({r[31:25], r[24:20], r[19:15], 3'b000, r[11:7], 7'h23}, ALU_ADD, 0, 0,
            1 + int'(r[7:6]));
      issue({r[31:25], r[24:20], r[19:15], 3'b010, r[11:7], 7'h23}, ALU_ADD, 0, 0,
            1 + int'(r[9:8]));
    end
    end_test("load_store");

    repeat (2) begin
      r = $random(seed);
      issue({r[31:25], r[24:20], r[19:15], 3'b000, r[11:7], 7'h63}, ALU_EQ, 0, 0, 0);
      issue({r[31:25], r[24:20], r[19:15], 3'b001, r[11:7], 7'h63}, ALU_NE, 0, 1, 0);
      issue({r[31:25], r[24:20], r[19:15], 3'b100, r[11:7], 7'h63}, ALU_LT, 0, 0, 0);
      issue({r[31:25], r[24:20], r[19:15], 3'b110, r[11:7], 7'h63}, ALU_LTU, 0, 1, 0);
      issue({r[31:25], r[24:20], r[19:15], 3'b111, r[11:7], 7'h63}, ALU_GEU, 0, 1, 0);
    end
    end_test("branch");

    repeat (2) begin
      r = $random(seed);
      issue({r[31:12], r[11:7], 7'h6f}, ALU_ADD, 0, 0, 0);
      issue({r[31:20], r[19:15], 3'b000, r[11:7], 7'h67}, ALU_ADD, 0, 0, 0);
    end
    end_test("jump");

    r = $random(seed);
    issue({r[31:7], 7'h7f}, ALU_ADD, 1, 0, 0);
    issue({7'h01, r[24:20], r[19:15], 3'b000, r[11:7], 7'h33}, ALU_ADD, 1, 0, 0);
    issue({r[31:20], r[19:15], 3'b001, r[11:7], 7'h67}, ALU_ADD, 1, 0, 0);
    issue({r[31:20], r[19:15], 3'b011, r[11:7], 7'h03}, ALU_ADD, 1, 0, 0);
    issue({r[31:25], r[24:20], r[19:15], 3'b011, r[11:7], 7'h23}, ALU_ADD, 1, 0, 0);
    issue({r[31:25], r[24:20], r[19:15], 3'b010, r[11:7], 7'h63}, ALU_ADD, 1, 1, 0);
    issue({7'h20, r[24:20], r[19:15], 3'b001, r[11:7], 7'h13}, ALU_ADD, 1, 0, 0);
    end_test("illegal");

    $display("Tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+include
verilog/id_pkg.sv
verilog/id_ctrl_if.sv
verilog/id_decoder.sv
verilog/id_operand_mux.sv
verilog/id_issue_fsm.sv
verilog/id_stage.sv
verification/tb_id_stage.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_id_stage
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
